/* mac_pipeline.f */
src/mac_pkg.sv
src/mul_stage.sv
src/accum_stage.sv
src/saturate_stage.sv
src/mac_pipeline_top.sv
verification/mac_pipeline_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MAC pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert \
	--top-module mac_pipeline_tb \
	-f mac_pipeline.f \
	-o mac_pipeline_sim

if ! ./obj_dir/mac_pipeline_sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	exit 1
fi

grep -q 'TEST PASSED' "$LOG"

/* src/accum_stage.sv */
// One register stage; sums wrap modulo 2**64 and the running total survives bubbles
`timescale 1ns/1ps
`default_nettype none

module accum_stage import mac_pkg::*; (
	input  logic       CLK,
	input  logic       rst_n_i,
	input  prod_item_s prod_i,
	output sum_item_s  sum_o
);

	// ====================
	// Addend select
	// ====================

	// Last valid sum, which is also the output payload
	result_t acc_q;
	// Valid bit of the output slot
	logic valid_q;

	// Second operand of the adder
	result_t addend_d;
	// Next sum
	result_t sum_d;

	always_comb begin
		unique case (prod_i.op)
			OP_MUL: begin
				addend_d = '0;
			end
			OP_MADD: begin
				// Sign extended 32-bit addend
				addend_d = result_t'(prod_i.c);
			end
			OP_CASC: begin
				// Extend to 64 bits, then shift; the top cascade bits fall off
				addend_d = result_t'(prod_i.pcin) <<< CASCADE_SHIFT;
			end
			OP_ACC: begin
				addend_d = acc_q;
			end
			default: begin
				addend_d = '0;
			end
		endcase
	end

	// Plain wrapping add
	assign sum_d = prod_i.product + addend_d;

	// ====================
	// Sum register
	// ====================

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			acc_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= prod_i.valid;
			// Only real items move the running total
			if (prod_i.valid) begin
				acc_q <= sum_d;
			end
		end
	end

	// Output slot reads zero on a bubble while the total is held
	assign sum_o.valid = valid_q;
	assign sum_o.sum   = valid_q ? acc_q : '0;

	// ====================
	// Checks
	// ====================

	// Output valid is the input valid one clock late
	a_valid_follows: assert property (
		@(posedge CLK) disable iff (!rst_n_i)
		sum_o.valid == $past(prod_i.valid)
	);

endmodule : accum_stage

`default_nettype wire

/* src/mac_pipeline_top.sv */
// Fixed four-clock latency, one item per clock, no back-pressure; reset zeroes the accumulator
`timescale 1ns/1ps
`default_nettype none

module mac_pipeline_top import mac_pkg::*; (
	input  logic      CLK,
	input  logic      rst_n_i,
	input  mac_req_s  req_i,
	output mac_resp_s resp_o
);

	// ====================
	// Stage links
	// ====================

	// Product item after edge two
	prod_item_s prod;
	// Sum item after edge three
	sum_item_s sum;

	// Operand and product registers
	mul_stage u_mul_stage (
		.CLK     (CLK),
		.rst_n_i (rst_n_i),
		.req_i   (req_i),
		.prod_o  (prod)
	);

	// Addend select and running total
	accum_stage u_accum_stage (
		.CLK     (CLK),
		.rst_n_i (rst_n_i),
		.prod_i  (prod),
		.sum_o   (sum)
	);

	// Full result plus saturated copy
	saturate_stage u_saturate_stage (
		.CLK     (CLK),
		.rst_n_i (rst_n_i),
		.sum_i   (sum),
		.resp_o  (resp_o)
	);

endmodule : mac_pipeline_top

`default_nettype wire

/* src/mac_pkg.sv */
// Shared widths and types; operands are signed two's complement and the cascade input is signed
`default_nettype none

package mac_pkg;

	// ====================
	// Datapath widths
	// ====================

	// Operands and addend
	localparam int OPERAND_W = 32;
	// Cascade input from a neighbouring slice
	localparam int CASCADE_W = 48;
	// Cascade input lands above the low product word
	localparam int CASCADE_SHIFT = 32;
	// Full product and sum
	localparam int RESULT_W = 64;
	// Saturated output copy
	localparam int NARROW_W = 32;

	// Input to output delay in clocks
	localparam int MAX_LATENCY = 4;

	// ====================
	// Vector types
	// ====================

	typedef logic signed [OPERAND_W-1:0] operand_t;
	typedef logic signed [CASCADE_W-1:0] cascade_t;
	typedef logic signed [RESULT_W-1:0] result_t;
	typedef logic signed [NARROW_W-1:0] narrow_t;

	// Clamp limits of the narrow output
	localparam narrow_t NARROW_MAX = {1'b0, {(NARROW_W-1){1'b1}}};
	localparam narrow_t NARROW_MIN = {1'b1, {(NARROW_W-1){1'b0}}};

	// Operation selector
	typedef enum logic [1:0] {
		OP_MUL  = 2'd0,  // product only
		OP_MADD = 2'd1,  // product plus addend
		OP_CASC = 2'd2,  // product plus shifted cascade
		OP_ACC  = 2'd3   // product plus last result
	} mac_op_e;

	// ====================
	// Stage items
	// ====================

	// Item entering the pipeline
	typedef struct packed {
		logic     valid;
		mac_op_e  op;
		operand_t a;
		operand_t b;
		operand_t c;
		cascade_t pcin;
	} mac_req_s;

	// Multiplier output with the operands still needed downstream
	typedef struct packed {
		logic     valid;
		mac_op_e  op;
		result_t  product;
		operand_t c;
		cascade_t pcin;
	} prod_item_s;

	// Accumulator output
	typedef struct packed {
		logic    valid;
		result_t sum;
	} sum_item_s;

	// Item leaving the pipeline
	typedef struct packed {
		logic    valid;
		result_t result;
		narrow_t narrow;
		logic    ovf;
	} mac_resp_s;

endpackage : mac_pkg

`default_nettype wire

/* src/mul_stage.sv */
// Two register stages with no stall; a low valid loads zero payload as the enable-low case does
`timescale 1ns/1ps
`default_nettype none

module mul_stage import mac_pkg::*; (
	input  logic       CLK,
	input  logic       rst_n_i,
	input  mac_req_s   req_i,
	output prod_item_s prod_o
);

	// ====================
	// Operand register
	// ====================

	// Request as sampled at the first edge
	mac_req_s req_q;

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			req_q <= '0;
		end else if (req_i.valid) begin
			req_q <= req_i;
		end else begin
			// Bubble clears the whole item
			req_q <= '0;
		end
	end

	// ====================
	// Product register
	// ====================

	// Full signed product
	result_t product_d;

	// Both sides sign extended to the result width first
	// Low 64 bits of the wide product equal the exact 32x32 signed product
	assign product_d = result_t'(req_q.a) * result_t'(req_q.b);

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			prod_o <= '0;
		end else if (req_q.valid) begin
			prod_o.valid   <= 1'b1;
			prod_o.op      <= req_q.op;
			prod_o.product <= product_d;
			// Addend and cascade ride along unchanged
			prod_o.c       <= req_q.c;
			prod_o.pcin    <= req_q.pcin;
		end else begin
			prod_o <= '0;
		end
	end

	// ====================
	// Checks
	// ====================

	// A valid request shows up as a valid product two clocks later
	a_valid_two_cycles: assert property (
		@(posedge CLK) disable iff (!rst_n_i)
		req_i.valid |-> ##2 prod_o.valid
	);

	// Idle product slot carries no stale payload
	a_idle_product_zero: assert property (
		@(posedge CLK) disable iff (!rst_n_i)
		!prod_o.valid |-> (prod_o.product == '0)
	);

endmodule : mul_stage

`default_nettype wire

/* src/saturate_stage.sv */
// One register stage; narrow clamps to the signed 32-bit limits and ovf flags any clamp
`timescale 1ns/1ps
`default_nettype none

module saturate_stage import mac_pkg::*; (
	input  logic      CLK,
	input  logic      rst_n_i,
	input  sum_item_s sum_i,
	output mac_resp_s resp_o
);

	// ====================
	// Range test
	// ====================

	// Bits that must all equal the narrow sign bit
	logic [RESULT_W-NARROW_W:0] upper_bits;
	// Sum fits in 32 signed bits
	logic in_range;
	// Narrow copy before the register
	narrow_t narrow_d;

	assign upper_bits = sum_i.sum[RESULT_W-1:NARROW_W-1];

	// All zeros or all ones means the value fits
	assign in_range = (~|upper_bits) | (&upper_bits);

	always_comb begin
		if (in_range) begin
			narrow_d = sum_i.sum[NARROW_W-1:0];
		end else if (sum_i.sum[RESULT_W-1]) begin
			// Too negative
			narrow_d = NARROW_MIN;
		end else begin
			// Too positive
			narrow_d = NARROW_MAX;
		end
	end

	// ====================
	// Output register
	// ====================

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			resp_o <= '0;
		end else if (sum_i.valid) begin
			resp_o.valid  <= 1'b1;
			resp_o.result <= sum_i.sum;
			resp_o.narrow <= narrow_d;
			resp_o.ovf    <= ~in_range;
		end else begin
			resp_o <= '0;
		end
	end

	// ====================
	// Checks
	// ====================

	// A clamp always lands on the limit matching the sign of the full result
	a_ovf_limit: assert property (
		@(posedge CLK) disable iff (!rst_n_i)
		resp_o.ovf |-> (resp_o.narrow == (resp_o.result[RESULT_W-1] ? NARROW_MIN : NARROW_MAX))
	);

endmodule : saturate_stage

`default_nettype wire

/* verification/mac_pipeline_tb.sv */
// Self-checking testbench; expects exactly MAX_LATENCY clocks from drive to response and no stall
`timescale 1ns/1ps
`default_nettype none

module mac_pipeline_tb import mac_pkg::*; ();

	// ====================
	// Run constants
	// ====================

	localparam int TABLE_LEN = 40;
	// Entries below this index are fixed corner cases
	localparam int FIXED_LEN = 20;
	localparam int RESET_CYCLES = 2;
	localparam int DRIVE_DELAY = 1;
	localparam int TIMEOUT_CYCLES = TABLE_LEN + MAX_LATENCY + 20;
	localparam logic [31:0] LFSR_SEED = 32'h28d9_1d49;
	// Signed 32-bit range for the reference saturation
	localparam longint NARROW_HI = 64'sd2147483647;
	localparam longint NARROW_LO = -64'sd2147483648;

	// Table index and the cycle at which its response is due
	typedef struct packed {
		int idx;
		int due;
	} pending_s;

	logic      CLK;
	logic      rst_n_i;
	mac_req_s  req_i;
	mac_resp_s resp_o;

	// Stimulus, expected response and test name per entry
	mac_req_s  req_tab [TABLE_LEN];
	mac_resp_s exp_tab [TABLE_LEN];
	string     name_tab [TABLE_LEN];

	pending_s    pending_q [$];
	pending_s    item;
	logic [31:0] lfsr_state;
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;

	mac_pipeline_top DUT (
		.CLK     (CLK),
		.rst_n_i (rst_n_i),
		.req_i   (req_i),
		.resp_o  (resp_o)
	);

	// 20 ns clock
	always #10 CLK = ~CLK;

	// ====================
	// Random source
	// ====================

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// ====================
	// Table setup
	// ====================

	task automatic set_entry(input int idx, input string name, input logic valid,
			input mac_op_e op, input operand_t a, input operand_t b, input operand_t c,
			input cascade_t pcin);
		name_tab[idx] = name;
		req_tab[idx] = '{valid: valid, op: op, a: a, b: b, c: c, pcin: pcin};
	endtask

	task automatic fill_table();
		logic [63:0] bits;
		// Multiply corners
		set_entry(0, "mul_mixed", 1'b1, OP_MUL, 32'sd7, -32'sd3, '0, '0);
		set_entry(1, "mul_neg_neg", 1'b1, OP_MUL, -32'sd5, -32'sd6, '0, '0);
		set_entry(2, "mul_max_max", 1'b1, OP_MUL, 32'sh7fff_ffff, 32'sh7fff_ffff, '0, '0);
		set_entry(3, "mul_min_min", 1'b1, OP_MUL, 32'sh8000_0000, 32'sh8000_0000, '0, '0);
		set_entry(4, "mul_min_max", 1'b1, OP_MUL, 32'sh8000_0000, 32'sh7fff_ffff, '0, '0);
		set_entry(5, "bubble_a", 1'b0, OP_MADD, 32'sd9, 32'sd9, 32'sd9, 48'sd9);
		// Addend, including both exact limits
		set_entry(6, "madd_small", 1'b1, OP_MADD, 32'sd100, 32'sd200, -32'sd50, '0);
		set_entry(7, "madd_at_max", 1'b1, OP_MADD, 32'sh1_0000, 32'sh8000, -32'sd1, '0);
		set_entry(8, "madd_at_min", 1'b1, OP_MADD, -32'sh1_0000, 32'sh8000, '0, '0);
		set_entry(9, "madd_below", 1'b1, OP_MADD, -32'sh1_0000, 32'sh8000, -32'sd1, '0);
		// Cascade lands in the upper word
		set_entry(10, "casc_plus", 1'b1, OP_CASC, 32'sd3, 32'sd4, '0, 48'sh0000_0000_0001);
		set_entry(11, "casc_minus", 1'b1, OP_CASC, 32'sd3, 32'sd4, '0, 48'shffff_ffff_ffff);
		set_entry(12, "casc_trunc", 1'b1, OP_CASC, 32'sd5, 32'sd5, '0, 48'sh8000_0000_0001);
		// Accumulation run across bubbles
		set_entry(13, "acc_start", 1'b1, OP_MUL, 32'sd10, 32'sd10, '0, '0);
		set_entry(14, "acc_one", 1'b1, OP_ACC, 32'sd2, 32'sd3, '0, '0);
		set_entry(15, "bubble_b", 1'b0, OP_ACC, 32'sd1000, 32'sd1000, '0, '0);
		set_entry(16, "acc_two", 1'b1, OP_ACC, 32'sd4, 32'sd5, '0, '0);
		set_entry(17, "bubble_c", 1'b0, OP_ACC, 32'sd77, 32'sd77, '0, '0);
		set_entry(18, "bubble_d", 1'b0, OP_MUL, '0, '0, '0, '0);
		set_entry(19, "acc_three", 1'b1, OP_ACC, -32'sd100, 32'sd1, '0, '0);
		// Random back-to-back items, now and then a bubble with a dirty payload
		for (int i = FIXED_LEN; i < TABLE_LEN; i++) begin
			name_tab[i] = $sformatf("rand_%0d", i);
			bits = random_bits(3);
			req_tab[i].valid = (bits[2:0] != 3'd0);
			bits = random_bits(2);
			req_tab[i].op = mac_op_e'(bits[1:0]);
			bits = random_bits(32);
			req_tab[i].a = bits[31:0];
			bits = random_bits(32);
			req_tab[i].b = bits[31:0];
			// Small b on some items keeps results inside the narrow range
			if (random_bits(1) != 64'd0) begin
				req_tab[i].b = {{20{bits[11]}}, bits[11:0]};
			end
			bits = random_bits(32);
			req_tab[i].c = bits[31:0];
			bits = random_bits(48);
			req_tab[i].pcin = bits[47:0];
		end
	endtask

	// ====================
	// Reference model
	// ====================

	task automatic build_expected();
		longint prev;
		longint prod;
		longint sum;
		mac_resp_s r;
		prev = 0;
		for (int i = 0; i < TABLE_LEN; i++) begin
			r = '0;
			if (req_tab[i].valid) begin
				prod = longint'(req_tab[i].a) * longint'(req_tab[i].b);
				case (req_tab[i].op)
					OP_MUL:  sum = prod;
					OP_MADD: sum = prod + longint'(req_tab[i].c);
					// Only the low 32 cascade bits survive in a 64-bit sum
					OP_CASC: sum = prod + longint'({req_tab[i].pcin[31:0], 32'h0});
					default: sum = prod + prev;
				endcase
				// Running total moves on valid items only
				prev = sum;
				r.valid = 1'b1;
				r.result = sum;
				if (sum > NARROW_HI) begin
					r.narrow = 32'h7fff_ffff;
					r.ovf = 1'b1;
				end else if (sum < NARROW_LO) begin
					r.narrow = 32'h8000_0000;
					r.ovf = 1'b1;
				end else begin
					r.narrow = sum[31:0];
				end
			end
			exp_tab[i] = r;
		end
	endtask

	// ====================
	// Checking
	// ====================

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic compare_response(input int idx);
		check_value({name_tab[idx], " valid"}, 64'(exp_tab[idx].valid), 64'(resp_o.valid));
		check_value({name_tab[idx], " result"}, exp_tab[idx].result, resp_o.result);
		check_value({name_tab[idx], " narrow"}, 64'(exp_tab[idx].narrow), 64'(resp_o.narrow));
		check_value({name_tab[idx], " ovf"}, 64'(exp_tab[idx].ovf), 64'(resp_o.ovf));
	endtask

	// Outputs are sampled on the falling edge, away from register updates
	always @(negedge CLK) begin
		if (rst_n_i) begin
			if (pending_q.size() != 0 && pending_q[0].due == cyc) begin
				item = pending_q.pop_front();
				compare_response(item.idx);
			end else if (resp_o.valid) begin
				errors++;
				$display("error: response valid at cycle %0d with no item due", cyc);
			end else begin
				// Idle slot must carry a zero payload
				check_value("idle result", '0, resp_o.result);
				check_value("idle narrow", '0, 64'(resp_o.narrow));
				check_value("idle ovf", '0, 64'(resp_o.ovf));
			end
		end
	end

	// Cycle count and run limit
	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("error: timeout after %0d cycles, checks %0d errors %0d",
				cyc, checks, errors + 1);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ====================
	// Stimulus
	// ====================

	initial begin
		CLK = 1'b0;
		rst_n_i = 1'b0;
		req_i = '0;
		lfsr_state = LFSR_SEED;
		fill_table();
		build_expected();
		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DELAY;
		rst_n_i = 1'b1;
		// One entry per clock; its response shows MAX_LATENCY clocks after the drive
		for (int i = 0; i < TABLE_LEN; i++) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			req_i = req_tab[i];
			pending_q.push_back('{idx: i, due: cyc + MAX_LATENCY});
		end
		@(posedge CLK);
		#DRIVE_DELAY;
		req_i = '0;
		while (pending_q.size() != 0) begin
			@(negedge CLK);
		end
		// One more idle sample after the last item
		@(negedge CLK);
		#1;
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule : mac_pipeline_tb

`default_nettype wire
